//--- include/bru_settings.svh
// ----------------------------------------------------------------------
// branch resolution unit settings
// widths and op codes shared by the design and the testbench
// ----------------------------------------------------------------------
`ifndef BRU_SETTINGS_SVH
`define BRU_SETTINGS_SVH

`define BRU_XLEN       32   // data and pc width
`define BRU_PR_BITS    7    // physical register index
`define BRU_ROB_BITS   7    // rob index
`define BRU_IMM20_BITS 20   // packed immediate

// op codes, jumps then lui/auipc then branches
`define BRU_OP_JALR   4'd0
`define BRU_OP_CJALR  4'd1
`define BRU_OP_JAL    4'd2
`define BRU_OP_CJAL   4'd3
`define BRU_OP_CJ     4'd4
`define BRU_OP_CJR    4'd5
`define BRU_OP_LUI    4'd6
`define BRU_OP_AUIPC  4'd7
`define BRU_OP_BEQ    4'd8
`define BRU_OP_BNE    4'd9
`define BRU_OP_CBEQZ  4'd10
`define BRU_OP_CBNEZ  4'd11
`define BRU_OP_BLT    4'd12
`define BRU_OP_BGE    4'd13
`define BRU_OP_BLTU   4'd14
`define BRU_OP_BGEU   4'd15

`endif

//--- design/bru_pkg.sv
// ----------------------------------------------------------------------
// branch resolution unit types
// plain vector typedefs used across the pipeline and testbench
// ----------------------------------------------------------------------
`include "bru_settings.svh"

package bru_pkg;

    // ------------------------------------------------------------------
    // data path

    typedef logic [`BRU_XLEN-1:0] bru_word_t;         // data or pc value

    typedef logic [`BRU_IMM20_BITS-1:0] bru_imm20_t;  // packed immediate

    // ------------------------------------------------------------------
    // control and bookkeeping

    // op code, values in the settings header
    typedef logic [3:0] bru_op_t;

    typedef logic [`BRU_PR_BITS-1:0] bru_pr_t;        // dest phys reg

    typedef logic [`BRU_ROB_BITS-1:0] bru_rob_t;      // rob entry

endpackage

//--- design/bru_operand_collect.sv
// ----------------------------------------------------------------------
// branch resolution operand collection stage
// holds one issued op until both operands are in, expands imm20
// ----------------------------------------------------------------------
`include "bru_settings.svh"

module bru_operand_collect import bru_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    // issue from the iq
    input  logic       issue_valid,
    input  bru_op_t    issue_op,
    input  bru_word_t  issue_pc,
    input  bru_word_t  issue_pred_pc,
    input  bru_imm20_t issue_imm20,
    input  logic       issue_a_zero,
    input  logic       issue_a_forward,
    input  logic       issue_b_zero,
    input  logic       issue_b_forward,
    input  bru_pr_t    issue_dest_pr,
    input  bru_rob_t   issue_rob_index,
    output logic       issue_ready,
    // operand arrival
    input  logic       a_read_ack,
    input  bru_word_t  a_read_data,
    input  logic       b_read_ack,
    input  bru_word_t  b_read_data,
    input  bru_word_t  a_forward_data,
    input  bru_word_t  b_forward_data,
    // to execute
    input  logic       ex_stall,
    output logic       collect_launch,
    output bru_op_t    col_op,
    output bru_word_t  col_pc,
    output bru_word_t  col_pred_pc,
    output bru_word_t  col_imm32,
    output bru_word_t  col_a,
    output bru_word_t  col_b,
    output bru_pr_t    col_dest_pr,
    output bru_rob_t   col_rob_index
);

    // ------------------------------------------------------------------
    // held op

    logic       hold_valid;
    logic       a_zero, a_fwd, a_saved;
    logic       b_zero, b_fwd, b_saved;
    bru_word_t  a_saved_data, b_saved_data;
    bru_imm20_t hold_imm20;
    logic       a_present, b_present;
    logic       launch_ok;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            hold_valid <= 1'b0;
            a_zero     <= 1'b0;
            a_fwd      <= 1'b0;
            a_saved    <= 1'b0;
            b_zero     <= 1'b0;
            b_fwd      <= 1'b0;
            b_saved    <= 1'b0;
        end else if (issue_ready) begin
            hold_valid <= issue_valid;       // take a new op, or go empty
            a_zero     <= issue_a_zero;
            a_fwd      <= issue_a_forward;
            a_saved    <= 1'b0;
            b_zero     <= issue_b_zero;
            b_fwd      <= issue_b_forward;
            b_saved    <= 1'b0;
        end else begin
            // waiting, so latch whatever showed up this cycle
            a_saved <= a_saved | a_fwd | a_read_ack;
            b_saved <= b_saved | b_fwd | b_read_ack;
            a_fwd   <= 1'b0;                 // forward only good for one cycle
            b_fwd   <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            col_op        <= issue_op;
            col_pc        <= issue_pc;
            col_pred_pc   <= issue_pred_pc;
            hold_imm20    <= issue_imm20;
            col_dest_pr   <= issue_dest_pr;
            col_rob_index <= issue_rob_index;
        end else begin
            a_saved_data <= col_a;
            b_saved_data <= col_b;
        end
    end

    // ------------------------------------------------------------------
    // operand select and launch

    assign a_present = a_zero | a_saved | a_fwd | a_read_ack;
    assign b_present = b_zero | b_saved | b_fwd | b_read_ack;

    assign launch_ok      = a_present & b_present & ~ex_stall;
    assign issue_ready    = ~hold_valid | launch_ok;
    assign collect_launch = hold_valid & launch_ok;

    always_comb begin
        if (a_zero)       col_a = '0;
        else if (a_saved) col_a = a_saved_data;
        else if (a_fwd)   col_a = a_forward_data;
        else              col_a = a_read_data;

        if (b_zero)       col_b = '0;
        else if (b_saved) col_b = b_saved_data;
        else if (b_fwd)   col_b = b_forward_data;
        else              col_b = b_read_data;
    end

    // imm20 -> imm32, sign always in imm20[11]
    always_comb begin
        if (col_op == `BRU_OP_LUI || col_op == `BRU_OP_AUIPC) begin
            col_imm32 = {hold_imm20[11], hold_imm20[10:0], hold_imm20[19:12], 12'h0};
        end else if (col_op == `BRU_OP_JALR) begin
            col_imm32 = {{21{hold_imm20[11]}}, hold_imm20[10:0]};
        end else if (col_op[3]) begin     // conditional branches
            col_imm32 = {{20{hold_imm20[11]}}, hold_imm20[0], hold_imm20[10:1], 1'b0};
        end else begin                     // j-type jumps
            col_imm32 = {{12{hold_imm20[11]}}, hold_imm20[19:12], hold_imm20[0],
                         hold_imm20[10:1], 1'b0};
        end
    end

endmodule

//--- design/bru_execute.sv
// ----------------------------------------------------------------------
// branch resolution execute stage
// stage register plus target, taken, start pc and link data per op
// ----------------------------------------------------------------------
`include "bru_settings.svh"

module bru_execute import bru_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    // from collect
    input  logic      collect_launch,
    input  bru_op_t   col_op,
    input  bru_word_t col_pc,
    input  bru_word_t col_pred_pc,
    input  bru_word_t col_imm32,
    input  bru_word_t col_a,
    input  bru_word_t col_b,
    input  bru_pr_t   col_dest_pr,
    input  bru_rob_t  col_rob_index,
    output logic      ex_stall,
    // to writeback
    input  logic      wb_stall,
    output logic      ex_valid,
    output bru_op_t   ex_op,
    output logic      ex_is_taken,
    output bru_word_t ex_start_pc,
    output bru_word_t ex_target_pc,
    output bru_word_t ex_pred_pc,
    output bru_word_t ex_write_data,
    output bru_pr_t   ex_dest_pr,
    output bru_rob_t  ex_rob_index
);

    bru_word_t pc, imm32, a, b;

    bru_word_t pc_plus_imm, pc_plus_2, pc_plus_4, a_plus_imm;
    logic      low_lt;      // compare of bits 30:0 only
    logic      a_eq_b, a_eq_zero, a_lts_b, a_ltu_b;
    logic      cond;        // branch condition for the held op

    assign ex_stall = ex_valid & wb_stall;

    // ------------------------------------------------------------------
    // stage register

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ex_valid <= 1'b0;
        end else if (!ex_stall) begin
            ex_valid <= collect_launch;
        end
    end

    always_ff @(posedge CLK) begin
        if (!ex_stall) begin
            ex_op        <= col_op;
            pc           <= col_pc;
            ex_pred_pc   <= col_pred_pc;
            imm32        <= col_imm32;
            a            <= col_a;
            b            <= col_b;
            ex_dest_pr   <= col_dest_pr;
            ex_rob_index <= col_rob_index;
        end
    end

    // ------------------------------------------------------------------
    // adders and compares

    assign pc_plus_imm = pc + imm32;
    assign pc_plus_2   = pc + 32'd2;
    assign pc_plus_4   = pc + 32'd4;
    assign a_plus_imm  = a + imm32;

    assign low_lt    = a[30:0] < b[30:0];
    assign a_eq_b    = (a == b);
    assign a_eq_zero = (a == '0);
    // sign bits decide when they differ, low bits otherwise
    assign a_lts_b = (a[31] & ~b[31]) | (low_lt & (a[31] == b[31]));
    assign a_ltu_b = (~a[31] & b[31]) | (low_lt & (a[31] == b[31]));

    always_comb begin
        case (ex_op)
            `BRU_OP_BEQ:   cond = a_eq_b;
            `BRU_OP_BNE:   cond = ~a_eq_b;
            `BRU_OP_CBEQZ: cond = a_eq_zero;
            `BRU_OP_CBNEZ: cond = ~a_eq_zero;
            `BRU_OP_BLT:   cond = a_lts_b;
            `BRU_OP_BGE:   cond = ~a_lts_b;
            `BRU_OP_BLTU:  cond = a_ltu_b;
            `BRU_OP_BGEU:  cond = ~a_ltu_b;
            default:       cond = 1'b1;      // jumps always go
        endcase
    end

    // ------------------------------------------------------------------
    // per-op resolution

    always_comb begin
        ex_target_pc  = pc_plus_imm;
        ex_is_taken   = 1'b1;
        ex_start_pc   = pc_plus_2;
        ex_write_data = pc_plus_4;

        case (ex_op)
            `BRU_OP_JALR: begin
                ex_target_pc = a_plus_imm;
            end
            `BRU_OP_CJALR: begin
                ex_target_pc  = a;
                ex_start_pc   = pc;
                ex_write_data = pc_plus_2;
            end
            `BRU_OP_CJAL: begin
                ex_start_pc   = pc;
                ex_write_data = pc_plus_2;
            end
            `BRU_OP_CJ: begin
                ex_start_pc = pc;
            end
            `BRU_OP_CJR: begin
                ex_target_pc = a;
                ex_start_pc  = pc;
            end
            `BRU_OP_LUI: begin
                ex_is_taken   = 1'b0;
                ex_write_data = imm32;
            end
            `BRU_OP_AUIPC: begin
                ex_is_taken   = 1'b0;
                ex_write_data = pc_plus_imm;
            end
            default: begin
                // jal keeps the defaults, branches follow cond
                if (ex_op[3]) begin
                    ex_is_taken  = cond;
                    ex_target_pc = cond ? pc_plus_imm : pc_plus_4;
                    if (ex_op == `BRU_OP_CBEQZ || ex_op == `BRU_OP_CBNEZ) begin
                        ex_start_pc = pc;
                    end
                end
            end
        endcase
    end

endmodule

//--- design/bru_writeback.sv
// ----------------------------------------------------------------------
// branch resolution writeback stage
// drives reg writeback and branch notification, source of the stall
// ----------------------------------------------------------------------
`include "bru_settings.svh"

module bru_writeback import bru_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    // from execute
    input  logic      ex_valid,
    input  bru_op_t   ex_op,
    input  logic      ex_is_taken,
    input  bru_word_t ex_start_pc,
    input  bru_word_t ex_target_pc,
    input  bru_word_t ex_pred_pc,
    input  bru_word_t ex_write_data,
    input  bru_pr_t   ex_dest_pr,
    input  bru_rob_t  ex_rob_index,
    output logic      wb_stall,
    // register writeback
    output logic      wb_valid,
    output bru_word_t wb_data,
    output bru_pr_t   wb_pr,
    output bru_rob_t  wb_rob_index,
    input  logic      wb_ready,
    // branch notification
    output logic      branch_notif_valid,
    output bru_rob_t  branch_notif_rob_index,
    output logic      branch_notif_is_mispredict,
    output logic      branch_notif_is_taken,
    output bru_word_t branch_notif_start_pc,
    output bru_word_t branch_notif_target_pc,
    input  logic      branch_notif_ready
);

    logic      stage_valid;
    bru_op_t   stage_op;
    bru_word_t stage_pred_pc;
    logic      need_wb, need_notif;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            stage_valid <= 1'b0;
        end else if (!wb_stall) begin
            stage_valid <= ex_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!wb_stall) begin
            stage_op               <= ex_op;
            branch_notif_is_taken  <= ex_is_taken;
            branch_notif_start_pc  <= ex_start_pc;
            branch_notif_target_pc <= ex_target_pc;
            stage_pred_pc          <= ex_pred_pc;
            wb_data                <= ex_write_data;
            wb_pr                  <= ex_dest_pr;
            wb_rob_index           <= ex_rob_index;
        end
    end

    // links and lui/auipc write a reg, everything but lui/auipc notifies
    assign need_wb    = stage_valid & (stage_op <= `BRU_OP_CJAL || stage_op == `BRU_OP_LUI ||
                                       stage_op == `BRU_OP_AUIPC);
    assign need_notif = stage_valid & (stage_op != `BRU_OP_LUI && stage_op != `BRU_OP_AUIPC);

    // hold until every needed consumer can take it
    assign wb_stall = (need_wb & ~wb_ready) | (need_notif & ~branch_notif_ready);

    assign wb_valid           = need_wb & ~wb_stall;
    assign branch_notif_valid = need_notif & ~wb_stall;

    assign branch_notif_rob_index     = wb_rob_index;
    assign branch_notif_is_mispredict = (branch_notif_target_pc != stage_pred_pc);

endmodule

//--- design/bru_pipeline.sv
// ----------------------------------------------------------------------
// branch resolution unit pipeline
// operand collect, execute and writeback stages chained in order
// ----------------------------------------------------------------------
module bru_pipeline import bru_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    // issue
    input  logic       issue_valid,
    input  bru_op_t    issue_op,
    input  bru_word_t  issue_pc,
    input  bru_word_t  issue_pred_pc,
    input  bru_imm20_t issue_imm20,
    input  logic       issue_a_zero,
    input  logic       issue_a_forward,
    input  logic       issue_b_zero,
    input  logic       issue_b_forward,
    input  bru_pr_t    issue_dest_pr,
    input  bru_rob_t   issue_rob_index,
    output logic       issue_ready,
    // operand arrival
    input  logic       a_read_ack,
    input  bru_word_t  a_read_data,
    input  logic       b_read_ack,
    input  bru_word_t  b_read_data,
    input  bru_word_t  a_forward_data,
    input  bru_word_t  b_forward_data,
    // writeback
    output logic       wb_valid,
    output bru_word_t  wb_data,
    output bru_pr_t    wb_pr,
    output bru_rob_t   wb_rob_index,
    input  logic       wb_ready,
    // branch notification
    output logic       branch_notif_valid,
    output bru_rob_t   branch_notif_rob_index,
    output logic       branch_notif_is_mispredict,
    output logic       branch_notif_is_taken,
    output bru_word_t  branch_notif_start_pc,
    output bru_word_t  branch_notif_target_pc,
    input  logic       branch_notif_ready
);

    // collect -> execute
    logic      collect_launch, ex_stall;
    bru_op_t   col_op;
    bru_word_t col_pc, col_pred_pc, col_imm32, col_a, col_b;
    bru_pr_t   col_dest_pr;
    bru_rob_t  col_rob_index;

    // execute -> writeback
    logic      ex_valid, ex_is_taken, wb_stall;
    bru_op_t   ex_op;
    bru_word_t ex_start_pc, ex_target_pc, ex_pred_pc, ex_write_data;
    bru_pr_t   ex_dest_pr;
    bru_rob_t  ex_rob_index;

    bru_operand_collect u_collect (.*);

    bru_execute u_execute (.*);

    bru_writeback u_writeback (.*);

endmodule

//--- bench/bru_pipeline_props.sv
// ----------------------------------------------------------------------
// branch resolution unit assertions
// reset and output handshake rules, bound into the pipeline top
// ----------------------------------------------------------------------
module bru_pipeline_props (
    input logic CLK,
    input logic nRST,
    input logic issue_ready,
    input logic wb_valid,
    input logic wb_ready,
    input logic branch_notif_valid,
    input logic branch_notif_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // nothing leaves the unit during reset
    valids_low_in_reset: assert property (@(posedge CLK)
        !nRST |-> (!wb_valid && !branch_notif_valid))
        else $error("output valid seen while in reset");

    wb_needs_ready: assert property (@(posedge CLK) disable iff (!nRST)
        wb_valid |-> wb_ready)
        else $error("wb_valid pulsed with wb_ready low");

    notif_needs_ready: assert property (@(posedge CLK) disable iff (!nRST)
        branch_notif_valid |-> branch_notif_ready)
        else $error("branch_notif_valid pulsed with branch_notif_ready low");

    // collect stage starts empty
    ready_after_reset: assert property (@(posedge CLK)
        $rose(nRST) |=> issue_ready)
        else $error("issue_ready low after reset release");

endmodule

bind bru_pipeline bru_pipeline_props props (
    .CLK                (CLK),
    .nRST               (nRST),
    .issue_ready        (issue_ready),
    .wb_valid           (wb_valid),
    .wb_ready           (wb_ready),
    .branch_notif_valid (branch_notif_valid),
    .branch_notif_ready (branch_notif_ready)
);

//--- bench/bru_pipeline_tb.sv
// ----------------------------------------------------------------------
// branch resolution unit testbench
// file driven stimulus, in-order scoreboard on both output ports
// ----------------------------------------------------------------------
`include "bru_settings.svh"

module bru_pipeline_tb import bru_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic CLK, nRST;
    logic issue_valid, issue_ready;
    bru_op_t issue_op;
    bru_word_t issue_pc, issue_pred_pc;
    bru_imm20_t issue_imm20;
    logic issue_a_zero, issue_a_forward, issue_b_zero, issue_b_forward;
    bru_pr_t issue_dest_pr;
    bru_rob_t issue_rob_index;
    logic a_read_ack, b_read_ack;
    bru_word_t a_read_data, b_read_data, a_forward_data, b_forward_data;
    logic wb_valid, wb_ready, branch_notif_valid, branch_notif_ready;
    bru_word_t wb_data, branch_notif_start_pc, branch_notif_target_pc;
    bru_pr_t wb_pr;
    bru_rob_t wb_rob_index, branch_notif_rob_index;
    logic branch_notif_is_mispredict, branch_notif_is_taken;

    // test table filled from the data file
    string t_name[64];
    bru_op_t t_op[64];
    bru_word_t t_pc[64], t_pred[64], t_a[64], t_b[64], t_wdata[64], t_target[64];
    bru_imm20_t t_imm[64];
    logic [1:0] t_asrc[64], t_bsrc[64];    // 0 zero, 1 forward, 2 read
    bru_pr_t t_dest[64];
    bru_rob_t t_rob[64];
    logic t_taken[64], t_misp[64];
    int test_count = 0;
    int mismatches = 0;
    int other_errors = 0;
    int wb_q[$];
    int notif_q[$];

    bru_pipeline dut (.*);

    always #50 CLK = ~CLK;

    // random back-pressure on both consumers
    always @(posedge CLK) begin
        wb_ready           <= ($urandom % 4) != 0;
        branch_notif_ready <= ($urandom % 4) != 0;
    end

    // links plus lui and auipc
    function automatic logic writes_reg(bru_op_t op);
        case (op)
            `BRU_OP_JALR, `BRU_OP_CJALR, `BRU_OP_JAL, `BRU_OP_CJAL,
            `BRU_OP_LUI, `BRU_OP_AUIPC: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // every jump and every conditional branch
    function automatic logic notifies(bru_op_t op);
        case (op)
            `BRU_OP_JALR, `BRU_OP_CJALR, `BRU_OP_JAL, `BRU_OP_CJAL,
            `BRU_OP_CJ, `BRU_OP_CJR: return 1'b1;
            `BRU_OP_BEQ, `BRU_OP_BNE, `BRU_OP_CBEQZ, `BRU_OP_CBNEZ,
            `BRU_OP_BLT, `BRU_OP_BGE, `BRU_OP_BLTU, `BRU_OP_BGEU: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic bru_word_t expected_start(bru_op_t op, bru_word_t pc);
        case (op)
            `BRU_OP_CJALR, `BRU_OP_CJAL, `BRU_OP_CJ, `BRU_OP_CJR,
            `BRU_OP_CBEQZ, `BRU_OP_CBNEZ: return pc;
            default: return pc + 32'd2;    // full-size ops
        endcase
    endfunction

    task automatic compare_field(string name, string field, bru_word_t exp, bru_word_t act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %h actual %h", name, field, exp, act);
            mismatches++;
        end
    endtask

    // ------------------------------------------------------------------
    // scoreboard sampled mid-cycle

    always @(negedge CLK) begin
        int i;
        if (wb_valid) begin
            if (wb_q.size() == 0) begin
                $display("writeback seen with none outstanding, rob %h", wb_rob_index);
                other_errors++;
            end else begin
                i = wb_q.pop_front();
                compare_field(t_name[i], "rob", 32'(t_rob[i]), 32'(wb_rob_index));
                compare_field(t_name[i], "wb_data", t_wdata[i], wb_data);
                compare_field(t_name[i], "wb_pr", 32'(t_dest[i]), 32'(wb_pr));
            end
        end
        if (branch_notif_valid) begin
            if (notif_q.size() == 0) begin
                $display("notification seen with none outstanding, rob %h",
                         branch_notif_rob_index);
                other_errors++;
            end else begin
                i = notif_q.pop_front();
                compare_field(t_name[i], "rob", 32'(t_rob[i]), 32'(branch_notif_rob_index));
                compare_field(t_name[i], "target", t_target[i], branch_notif_target_pc);
                compare_field(t_name[i], "taken", 32'(t_taken[i]),
                              32'(branch_notif_is_taken));
                compare_field(t_name[i], "mispredict", 32'(t_misp[i]),
                              32'(branch_notif_is_mispredict));
                compare_field(t_name[i], "start_pc", expected_start(t_op[i], t_pc[i]),
                              branch_notif_start_pc);
            end
        end
    end

    // ------------------------------------------------------------------
    // watchdog allows 40 cycles per test

    initial begin
        wait (test_count > 0);
        repeat (test_count * 40) @(posedge CLK);
        $display("timeout: %0d writebacks and %0d notifications never arrived",
                 wb_q.size(), notif_q.size());
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        $display("TEST FAILED");
        $finish;
    end

    // ------------------------------------------------------------------
    // main sequence

    initial begin
        int fd, n, da, db, maxd;
        string line;
        void'($urandom(32'h434ac50c));
        CLK = 0;
        nRST = 0;
        issue_valid = 0;
        issue_op = '0;
        issue_pc = '0;
        issue_pred_pc = '0;
        issue_imm20 = '0;
        issue_a_zero = 0;
        issue_a_forward = 0;
        issue_b_zero = 0;
        issue_b_forward = 0;
        issue_dest_pr = '0;
        issue_rob_index = '0;
        a_read_ack = 0;
        b_read_ack = 0;
        a_read_data = '0;
        b_read_data = '0;
        a_forward_data = '0;
        b_forward_data = '0;
        wb_ready = 1;
        branch_notif_ready = 1;

        fd = $fopen("bench/bru_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            other_errors++;
        end else begin
            while (!$feof(fd) && test_count < 64) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                t_name[test_count], t_op[test_count], t_pc[test_count],
                                t_pred[test_count], t_imm[test_count], t_a[test_count],
                                t_b[test_count], t_asrc[test_count], t_bsrc[test_count],
                                t_dest[test_count], t_rob[test_count], t_wdata[test_count],
                                t_target[test_count], t_taken[test_count],
                                t_misp[test_count]);
                    if (n == 15) test_count++;
                end
            end
            $fclose(fd);
        end

        repeat (4) @(posedge CLK);
        nRST <= 1;
        repeat (2) @(posedge CLK);

        for (int i = 0; i < test_count; i++) begin
            @(posedge CLK);
            issue_valid     <= 1;
            issue_op        <= t_op[i];
            issue_pc        <= t_pc[i];
            issue_pred_pc   <= t_pred[i];
            issue_imm20     <= t_imm[i];
            issue_a_zero    <= (t_asrc[i] == 2'd0);
            issue_a_forward <= (t_asrc[i] == 2'd1);
            issue_b_zero    <= (t_bsrc[i] == 2'd0);
            issue_b_forward <= (t_bsrc[i] == 2'd1);
            issue_dest_pr   <= t_dest[i];
            issue_rob_index <= t_rob[i];
            a_forward_data  <= t_a[i];
            b_forward_data  <= t_b[i];
            a_read_data     <= t_a[i];
            b_read_data     <= t_b[i];
            a_read_ack      <= 0;
            b_read_ack      <= 0;
            @(negedge CLK);
            while (!issue_ready) @(negedge CLK);
            @(posedge CLK);                  // accepted at this edge
            issue_valid <= 0;
            if (writes_reg(t_op[i])) wb_q.push_back(i);
            if (notifies(t_op[i])) notif_q.push_back(i);
            // read acks 1 to 3 cycles into the wait
            da = (t_asrc[i] == 2'd2) ? 1 + int'($urandom % 3) : 0;
            db = (t_bsrc[i] == 2'd2) ? 1 + int'($urandom % 3) : 0;
            maxd = (da > db) ? da : db;
            for (int c = 1; c <= maxd; c++) begin
                @(posedge CLK);
                a_read_ack <= (c == da);
                b_read_ack <= (c == db);
            end
        end
        @(posedge CLK);
        a_read_ack <= 0;
        b_read_ack <= 0;

        while (wb_q.size() != 0 || notif_q.size() != 0) @(negedge CLK);
        repeat (5) @(negedge CLK);
        if (test_count == 0) begin
            $display("no tests were read from the data file");
            other_errors++;
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- bench/bru_tests.txt
# name op pc pred_pc imm20 a b a_src b_src dest_pr rob wdata target taken mispredict
# all hex, sources 0 zero 1 forward 2 read
jalr     0 00001000 00002010 00010 00002000 00000000 1 0 11 01 00001004 00002010 1 0
c_jalr   1 00001100 00000000 00000 00003000 00000000 2 0 12 02 00001102 00003000 1 1
jal      2 00001200 00001300 00100 00000000 00000000 0 0 13 03 00001204 00001300 1 0
c_jal    3 00001400 00001404 00020 00000000 00000000 0 0 14 04 00001402 00001420 1 1
c_j      4 00001500 000014f0 ffff1 00000000 00000000 0 0 15 05 00000000 000014f0 1 0
c_jr     5 00001600 00004444 00000 00004444 00000000 1 0 16 06 00000000 00004444 1 0
lui      6 00000000 00000000 12345 00000000 00000000 0 0 17 07 34512000 00000000 0 0
auipc    7 00010000 00000000 00001 00000000 00000000 0 0 18 08 00110000 00000000 0 0
beq_t    8 00002000 00002040 00040 00000005 00000005 1 2 19 09 00000000 00002040 1 0
beq_n    8 00002000 00002040 00040 00000005 00000006 2 2 1a 0a 00000000 00002004 0 1
bne_t    9 00002000 00002040 00040 00000005 00000006 2 1 1b 0b 00000000 00002040 1 0
bne_n    9 00002000 00002040 00040 00000007 00000007 1 1 1c 0c 00000000 00002004 0 1
cbeqz_t  a 00002000 00002004 00040 00000000 00000000 0 0 1d 0d 00000000 00002040 1 1
cbeqz_n  a 00002000 00002040 00040 00000001 00000000 2 0 1e 0e 00000000 00002004 0 1
cbnez_t  b 00002000 00002040 00040 00000001 00000000 1 0 1f 0f 00000000 00002040 1 0
cbnez_n  b 00002000 00002040 00040 00000000 00000000 0 0 20 10 00000000 00002004 0 1
blt_t    c 00002000 00002040 00040 80000000 00000001 2 1 21 11 00000000 00002040 1 0
blt_n    c 00002000 00002040 00040 00000001 80000000 2 2 22 12 00000000 00002004 0 1
bge_t    d 00002000 00002040 00040 00000001 80000000 1 2 23 13 00000000 00002040 1 0
bge_n    d 00002000 00002040 00040 80000000 00000001 2 2 24 14 00000000 00002004 0 1
bltu_t   e 00002000 00002040 00040 00000001 80000000 2 1 25 15 00000000 00002040 1 0
bltu_n   e 00002000 00002040 00040 80000000 00000001 1 1 26 16 00000000 00002004 0 1
bgeu_t   f 00002000 00002040 00040 80000000 00000001 2 2 27 17 00000000 00002040 1 0
bgeu_n   f 00002000 00002040 00040 00000001 80000000 1 2 28 18 00000000 00002004 0 1

//--- bru_pipeline.f
+incdir+include
design/bru_pkg.sv
design/bru_operand_collect.sv
design/bru_execute.sv
design/bru_writeback.sv
design/bru_pipeline.sv
bench/bru_pipeline_props.sv
bench/bru_pipeline_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the branch resolution unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f bru_pipeline.f \
    --top-module bru_pipeline_tb -o bru_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/bru_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
